/* hdl/na_pkg.sv */
// ******************************
// Network adapter shared types
// ******************************

package na_pkg;

   // Link and queue sizing
   localparam int unsigned NOC_DATA_WIDTH = 32;          // Flit payload bits
   localparam int unsigned FIFO_DEPTH     = 16;          // Both flit queues
   localparam int unsigned PTR_WIDTH      = $clog2(FIFO_DEPTH);
   localparam int unsigned CNT_WIDTH      = $clog2(FIFO_DEPTH) + 1; // 0..FIFO_DEPTH

   // Mesh size reported in config window
   localparam int unsigned NOC_XDIM = 4;
   localparam int unsigned NOC_YDIM = 4;

   // Address decode, window code sits in adr[21:20]
   localparam int unsigned WIN_LSB   = 20;
   localparam int unsigned OFF_WIDTH = 20;               // Offset inside a window

   localparam logic [1:0] WIN_CONF = 2'b00;              // Read-only config words
   localparam logic [1:0] WIN_MP   = 2'b01;              // Message passing
   localparam logic [1:0] WIN_DMA  = 2'b10;              // Not implemented

   // Config window offsets
   localparam logic [OFF_WIDTH-1:0] CONF_TILE_ID  = 'h0;
   localparam logic [OFF_WIDTH-1:0] CONF_XDIM     = 'h4;
   localparam logic [OFF_WIDTH-1:0] CONF_YDIM     = 'h8;
   localparam logic [OFF_WIDTH-1:0] CONF_FEATURES = 'hc;

   // Feature word bit positions
   localparam int unsigned FEATURE_MP  = 0;              // Reads as 1
   localparam int unsigned FEATURE_DMA = 1;              // Reads as 0

   // Message passing offsets
   localparam logic [OFF_WIDTH-1:0] MP_SEND     = 'h0;   // Word, packet continues
   localparam logic [OFF_WIDTH-1:0] MP_SEND_END = 'h4;   // Word, packet ends
   localparam logic [OFF_WIDTH-1:0] MP_RECV     = 'h8;   // Pop one received word
   localparam logic [OFF_WIDTH-1:0] MP_STATUS   = 'hc;   // Waiting packet count

   typedef enum logic [1:0] {
      PAYLOAD = 2'b00,
      HEAD    = 2'b01,
      TAIL    = 2'b10,
      SINGLE  = 2'b11
   } flit_type_e;

   typedef struct packed {
      flit_type_e                ftype;                  // Framing bits on top
      logic [NOC_DATA_WIDTH-1:0] data;
   } flit_t;

   typedef struct packed {
      logic                      valid;                  // Write strobe from slave
      logic                      last;                   // End of packet
      logic [NOC_DATA_WIDTH-1:0] data;
   } send_req_t;

   typedef struct packed {
      logic                      empty;                  // Receive queue empty
      logic [NOC_DATA_WIDTH-1:0] head_data;              // Oldest queued word
      logic [CNT_WIDTH-1:0]      packets;                // Complete packets waiting
   } recv_stat_t;

endpackage

/* hdl/na_flit_fifo.sv */
// ******************************
// Flit FIFO
// ******************************
`timescale 1ns/10ps

module na_flit_fifo (
   input  logic                         clk_i,
   input  logic                         rst_n_i,
   input  logic                         push_i,
   input  na_pkg::flit_t                push_flit_i,
   input  logic                         pop_i,
   output na_pkg::flit_t                head_flit_o,
   output logic                         empty_o,
   output logic                         full_o,
   output logic [na_pkg::CNT_WIDTH-1:0] count_o
);

   import na_pkg::*;

   flit_t                mem [FIFO_DEPTH];               // Flit storage
   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic [CNT_WIDTH-1:0] count;

   // Storage write, no reset on payload
   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem[wr_ptr] <= push_flit_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) wr_ptr <= wr_ptr + 1'b1;            // Wraps at depth
         if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                     // Idle or both
         endcase
      end
   end

   assign head_flit_o = mem[rd_ptr];                     // First word fall through
   assign empty_o     = (count == '0);
   assign full_o      = (count == CNT_WIDTH'(FIFO_DEPTH));
   assign count_o     = count;

   // Callers gate push and pop with full and empty
   a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      push_i |-> !full_o);
   a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> !empty_o);

endmodule

/* hdl/na_bus_slave.sv */
// ******************************
// Adapter bus slave
// ******************************
`timescale 1ns/10ps

module na_bus_slave #(
   parameter int unsigned TILE_ID = 0
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic [31:0]        wbs_adr_i,
   input  logic [31:0]        wbs_dat_i,
   input  logic               wbs_we_i,
   input  logic               wbs_cyc_i,
   input  logic               wbs_stb_i,
   output logic               wbs_ack_o,
   output logic               wbs_err_o,
   output logic [31:0]        wbs_dat_o,
   output na_pkg::send_req_t  send_req_o,
   input  logic               send_ready_i,
   input  na_pkg::recv_stat_t recv_stat_i,
   output logic               recv_pop_o
);

   import na_pkg::*;

   logic                 req;                            // Active bus cycle
   logic [1:0]           win;
   logic [OFF_WIDTH-1:0] off;

   assign req = wbs_cyc_i & wbs_stb_i;
   assign win = wbs_adr_i[WIN_LSB +: 2];
   assign off = wbs_adr_i[OFF_WIDTH-1:0];

   always_comb begin
      wbs_ack_o         = 1'b0;
      wbs_err_o         = 1'b0;
      wbs_dat_o         = '0;
      send_req_o.valid  = 1'b0;
      send_req_o.last   = (off == MP_SEND_END);
      send_req_o.data   = wbs_dat_i;
      recv_pop_o        = 1'b0;
      if (req) begin
         case (win)
            WIN_CONF: begin
               wbs_err_o = wbs_we_i;                     // Config is read-only
               wbs_ack_o = !wbs_we_i;
               case (off)
                  CONF_TILE_ID:  wbs_dat_o = 32'(TILE_ID);
                  CONF_XDIM:     wbs_dat_o = 32'(NOC_XDIM);
                  CONF_YDIM:     wbs_dat_o = 32'(NOC_YDIM);
                  CONF_FEATURES: begin
                     wbs_dat_o              = '0;
                     wbs_dat_o[FEATURE_MP]  = 1'b1;      // Message passing present
                     wbs_dat_o[FEATURE_DMA] = 1'b0;      // No DMA engine
                  end
                  default:       wbs_dat_o = '0;         // Unused config word
               endcase
            end
            WIN_MP: begin
               case (off)
                  MP_SEND, MP_SEND_END: begin
                     send_req_o.valid = wbs_we_i;
                     wbs_ack_o        = wbs_we_i & send_ready_i; // Stall when full
                     wbs_err_o        = !wbs_we_i;
                  end
                  MP_RECV: begin
                     wbs_ack_o  = !wbs_we_i;
                     wbs_err_o  = wbs_we_i;
                     recv_pop_o = !wbs_we_i & !recv_stat_i.empty;
                     wbs_dat_o  = recv_stat_i.empty ? '0 : recv_stat_i.head_data;
                  end
                  MP_STATUS: begin
                     wbs_ack_o = !wbs_we_i;
                     wbs_err_o = wbs_we_i;
                     wbs_dat_o = 32'(recv_stat_i.packets);
                  end
                  default: wbs_err_o = 1'b1;             // Unmapped MP offset
               endcase
            end
            WIN_DMA: wbs_err_o = 1'b1;                   // Engine not present
            default: wbs_err_o = 1'b1;
         endcase
      end
   end

   // One response at most, and only inside a request
   a_bus_resp : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wbs_ack_o || wbs_err_o) |-> (req && !(wbs_ack_o && wbs_err_o)));

endmodule

/* hdl/na_mp_send.sv */
// ******************************
// Message send path
// ******************************
`timescale 1ns/10ps

module na_mp_send (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  na_pkg::send_req_t send_req_i,
   output logic              send_ready_o,
   output na_pkg::flit_t     noc_out_flit_o,
   output logic              noc_out_valid_o,
   input  logic              noc_out_ready_i
);

   import na_pkg::*;

   typedef enum logic {IDLE, IN_PACKET} send_state_e;

   send_state_e state;                                   // Framing state
   flit_t       push_flit;
   logic        push;
   logic        pop;
   logic        empty;
   logic        full;

   assign send_ready_o = !full;
   assign push         = send_req_i.valid & !full;       // Only acked words
   assign pop          = noc_out_valid_o & noc_out_ready_i;

   // Pick flit type from framing state and end flag
   always_comb begin
      push_flit.data = send_req_i.data;
      if (state == IDLE) push_flit.ftype = send_req_i.last ? SINGLE : HEAD;
      else               push_flit.ftype = send_req_i.last ? TAIL : PAYLOAD;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state <= IDLE;
      end else if (push) begin
         state <= send_req_i.last ? IDLE : IN_PACKET;    // Back to idle at end
      end
   end

   na_flit_fifo u_send_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (push),
      .push_flit_i (push_flit),
      .pop_i       (pop),
      .head_flit_o (noc_out_flit_o),                     // Head drives the link
      .empty_o     (empty),
      .full_o      (full),
      .count_o     ()
   );

   assign noc_out_valid_o = !empty;

   // Link rule, offered flit waits unchanged
   a_flit_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (noc_out_valid_o && !noc_out_ready_i) |=> (noc_out_valid_o && $stable(noc_out_flit_o)));

endmodule

/* hdl/na_mp_recv.sv */
// ******************************
// Message receive path
// ******************************
`timescale 1ns/10ps

module na_mp_recv (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  na_pkg::flit_t      noc_in_flit_i,
   input  logic               noc_in_valid_i,
   output logic               noc_in_ready_o,
   input  logic               recv_pop_i,
   output na_pkg::recv_stat_t recv_stat_o,
   output logic               irq_o
);

   import na_pkg::*;

   flit_t                head_flit;
   logic                 push;
   logic                 empty;
   logic                 full;
   logic [CNT_WIDTH-1:0] fifo_count;                     // Queued flits
   logic [CNT_WIDTH-1:0] packets;                        // Complete packets queued
   logic                 pkt_in;
   logic                 pkt_out;

   assign noc_in_ready_o = !full;
   assign push           = noc_in_valid_i & noc_in_ready_o;

   // Packet ends on tail or single flit
   assign pkt_in  = push & (noc_in_flit_i.ftype inside {TAIL, SINGLE});
   assign pkt_out = recv_pop_i & (head_flit.ftype inside {TAIL, SINGLE});

   na_flit_fifo u_recv_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (push),
      .push_flit_i (noc_in_flit_i),
      .pop_i       (recv_pop_i),                         // Slave pops only if not empty
      .head_flit_o (head_flit),
      .empty_o     (empty),
      .full_o      (full),
      .count_o     (fifo_count)
   );

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         packets <= '0;
      end else if (pkt_in && !pkt_out) begin
         packets <= packets + 1'b1;
      end else if (pkt_out && !pkt_in) begin
         packets <= packets - 1'b1;
      end
   end

   always_comb begin
      recv_stat_o.empty     = empty;
      recv_stat_o.head_data = head_flit.data;
      recv_stat_o.packets   = packets;
   end

   assign irq_o = (packets != '0);                       // Any packet waiting

   // Counter tracks end flits still inside the queue
   a_pkt_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pkt_out |-> (packets != '0));
   a_pkt_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      packets <= fifo_count);

endmodule

/* hdl/na_compute_tile.sv */
// ******************************
// Compute tile adapter
// ******************************
`timescale 1ns/10ps

module na_compute_tile #(
   parameter int unsigned TILE_ID = 0
) (
   input  logic          clk_i,
   input  logic          rst_n_i,
   input  logic [31:0]   wbs_adr_i,
   input  logic [31:0]   wbs_dat_i,
   input  logic          wbs_we_i,
   input  logic          wbs_cyc_i,
   input  logic          wbs_stb_i,
   output logic          wbs_ack_o,
   output logic          wbs_err_o,
   output logic [31:0]   wbs_dat_o,
   input  na_pkg::flit_t noc_in_flit_i,
   input  logic          noc_in_valid_i,
   output logic          noc_in_ready_o,
   output na_pkg::flit_t noc_out_flit_o,
   output logic          noc_out_valid_o,
   input  logic          noc_out_ready_i,
   output logic          irq_o
);

   import na_pkg::*;

   send_req_t  send_req;                                 // Slave to send path
   logic       send_ready;
   recv_stat_t recv_stat;                                // Receive path to slave
   logic       recv_pop;

   na_bus_slave #(.TILE_ID(TILE_ID)) u_bus_slave (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .wbs_adr_i (wbs_adr_i), .wbs_dat_i (wbs_dat_i), .wbs_we_i (wbs_we_i),
      .wbs_cyc_i (wbs_cyc_i), .wbs_stb_i (wbs_stb_i),
      .wbs_ack_o (wbs_ack_o), .wbs_err_o (wbs_err_o), .wbs_dat_o (wbs_dat_o),
      .send_req_o (send_req), .send_ready_i (send_ready),
      .recv_stat_i (recv_stat), .recv_pop_o (recv_pop)
   );

   na_mp_send u_mp_send (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .send_req_i (send_req), .send_ready_o (send_ready),
      .noc_out_flit_o (noc_out_flit_o), .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i)                 // Single channel, no arbiter
   );

   na_mp_recv u_mp_recv (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .noc_in_flit_i (noc_in_flit_i), .noc_in_valid_i (noc_in_valid_i),
      .noc_in_ready_o (noc_in_ready_o), .recv_pop_i (recv_pop),
      .recv_stat_o (recv_stat), .irq_o (irq_o)
   );

endmodule

/* tb/tb_na_compute_tile.sv */
// ******************************
// Compute tile testbench
// ******************************
`timescale 1ns/10ps

module tb_na_compute_tile;

   import na_pkg::*;

   localparam int          PERIOD      = 100;
   localparam int          NUM_OPS     = 320;              // Bus and link operations
   localparam int          OP_CYCLES   = 40;               // Worst case per operation
   localparam longint      WATCHDOG_NS = longint'(PERIOD) * (10 + NUM_OPS * OP_CYCLES);
   localparam logic [31:0] MP_BASE     = 32'h0010_0000;    // Window 01

   logic        clk = 1'b0;
   logic        rst_n;
   logic [31:0] wbs_adr;
   logic [31:0] wbs_dat;
   logic        wbs_we;
   logic        wbs_cyc;
   logic        wbs_stb;
   logic        wbs_ack;
   logic        wbs_err;
   logic [31:0] wbs_rdat;
   flit_t       noc_in_flit;
   logic        noc_in_valid;
   logic        noc_in_ready;
   flit_t       noc_out_flit;
   logic        noc_out_valid;
   logic        noc_out_ready;
   logic        irq;

   logic [31:0] rng;                                       // Stimulus stream
   logic [31:0] rdy_rng;                                   // Link ready stream
   int          ready_mode;                                // 0 random, 1 low, 2 high
   int          errors;
   int          checks;
   flit_t       exp_out[$];                                // Expected outgoing flits
   flit_t       rx_q[$];                                   // Flits sent into the tile
   int          rx_pkts;                                   // Complete packets waiting
   logic        tx_in_pkt;                                 // Send framing model
   logic        held_valid;
   flit_t       held_flit;
   logic [31:0] rd;
   logic        ack;
   logic        err;
   flit_t       f;
   int          len;

   na_compute_tile #(.TILE_ID(5)) dut0 (
      .clk_i (clk), .rst_n_i (rst_n),
      .wbs_adr_i (wbs_adr), .wbs_dat_i (wbs_dat), .wbs_we_i (wbs_we),
      .wbs_cyc_i (wbs_cyc), .wbs_stb_i (wbs_stb),
      .wbs_ack_o (wbs_ack), .wbs_err_o (wbs_err), .wbs_dat_o (wbs_rdat),
      .noc_in_flit_i (noc_in_flit), .noc_in_valid_i (noc_in_valid),
      .noc_in_ready_o (noc_in_ready),
      .noc_out_flit_o (noc_out_flit), .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready), .irq_o (irq)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   task automatic check_equal(input string name, input logic [33:0] got,
                              input logic [33:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // One Wishbone access held until ack or err
   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat);
      @(negedge clk);
      wbs_cyc = 1'b1;
      wbs_stb = 1'b1;
      wbs_we  = we;
      wbs_adr = adr;
      wbs_dat = wdat;
      @(posedge clk);
      while (!(wbs_ack || wbs_err)) @(posedge clk);
      ack = wbs_ack;
      err = wbs_err;
      rd  = wbs_rdat;
      @(negedge clk);
      wbs_cyc = 1'b0;
      wbs_stb = 1'b0;
      wbs_we  = 1'b0;
   endtask

   // Read that must be acked with the expected word
   task automatic read_compare(input logic [31:0] adr, input logic [31:0] exp);
      bus_access(1'b0, adr, '0);
      check_equal("wbs_ack_o", ack, 1'b1);
      check_equal("wbs_dat_o", rd, exp);
   endtask

   // Framing rule applied to each acked word
   task automatic expect_send(input logic last, input logic [31:0] data);
      flit_t e;
      e.data  = data;
      e.ftype = tx_in_pkt ? (last ? TAIL : PAYLOAD) : (last ? SINGLE : HEAD);
      exp_out.push_back(e);
      tx_in_pkt = !last;
   endtask

   task automatic mp_write(input logic last, input logic [31:0] data);
      bus_access(1'b1, MP_BASE | (last ? MP_SEND_END : MP_SEND), data);
      check_equal("wbs_ack_o", ack, 1'b1);
      if (ack) expect_send(last, data);
   endtask

   task automatic expect_err(input logic we, input logic [31:0] adr);
      bus_access(we, adr, next_rand());
      check_equal("wbs_err_o", err, 1'b1);
      check_equal("wbs_ack_o", ack, 1'b0);
   endtask

   task automatic link_inject(input flit_t fl);
      @(negedge clk);
      noc_in_valid = 1'b1;
      noc_in_flit  = fl;
      @(posedge clk);
      while (!noc_in_ready) @(posedge clk);
      rx_q.push_back(fl);
      if (fl.ftype inside {TAIL, SINGLE}) rx_pkts++;
   endtask

   task automatic set_ready_mode(input int m);
      @(posedge clk);
      ready_mode = m;                                      // Driver picks it up at negedge
   endtask

   initial begin
      forever #(PERIOD / 2) clk = ~clk;
   end

   always @(negedge clk) begin
      rdy_rng = xorshift(rdy_rng);
      noc_out_ready = (ready_mode == 2) || (ready_mode == 0 && rdy_rng[7]);
   end

   // Outgoing link monitor with hold check
   always @(posedge clk) begin
      if (rst_n) begin
         if (held_valid) begin
            check_equal("noc_out_valid_o", noc_out_valid, 1'b1);
            check_equal("noc_out_flit_o", noc_out_flit, held_flit);
         end
         if (noc_out_valid && noc_out_ready) begin
            assert (exp_out.size() != 0) else begin
               errors++;
               $display("Flit left the link at %0t ns while none was expected", $time);
            end
            if (exp_out.size() != 0)
               check_equal("noc_out_flit_o", noc_out_flit, exp_out.pop_front());
         end
         held_valid = noc_out_valid && !noc_out_ready;
         held_flit  = noc_out_flit;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired, a bus or link transfer never completed");
      $display("Something failed");
      $finish;
   end

   initial begin
      rst_n         = 1'b0;
      wbs_adr       = '0;
      wbs_dat       = '0;
      wbs_we        = 1'b0;
      wbs_cyc       = 1'b0;
      wbs_stb       = 1'b0;
      noc_in_flit   = '0;
      noc_in_valid  = 1'b0;
      noc_out_ready = 1'b1;
      ready_mode    = 2;
      rng           = 32'd44;
      rdy_rng       = xorshift(32'd44);
      errors        = 0;
      checks        = 0;
      rx_pkts       = 0;
      tx_in_pkt     = 1'b0;
      held_valid    = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_equal("irq_o", irq, 1'b0);
      check_equal("noc_in_ready_o", noc_in_ready, 1'b1);
      // Configuration window
      read_compare(32'h0, 32'd5);
      read_compare(32'h4, 32'd4);
      read_compare(32'h8, 32'd4);
      read_compare(32'hc, 32'h1);
      read_compare(32'h10, 32'h0);
      // Illegal accesses leave both paths untouched
      expect_err(1'b1, 32'h0);
      expect_err(1'b1, MP_BASE | MP_RECV);
      expect_err(1'b0, MP_BASE | MP_SEND);
      expect_err(1'b0, 32'h0020_0000);
      expect_err(1'b1, 32'h0020_0004);
      expect_err(1'b0, 32'h0030_0000);
      check_equal("noc_out_valid_o", noc_out_valid, 1'b0);
      read_compare(MP_BASE | MP_STATUS, 32'h0);
      // Random packets out under random back-pressure
      set_ready_mode(0);
      for (int p = 0; p < 40; p++) begin
         len = 1 + int'(next_rand() % 5);
         for (int i = 0; i < len; i++) mp_write(i == len - 1, next_rand());
      end
      while (exp_out.size() != 0) @(posedge clk);
      // Random packets in and drained by software
      for (int r = 0; r < 2; r++) begin
         for (int p = 0; p < 3; p++) begin
            len = 1 + int'(next_rand() % 5);
            for (int i = 0; i < len; i++) begin
               f.data  = next_rand();
               f.ftype = (len == 1) ? SINGLE : (i == 0) ? HEAD : (i == len - 1) ? TAIL : PAYLOAD;
               link_inject(f);
            end
            @(negedge clk);
            noc_in_valid = 1'b0;
            check_equal("irq_o", irq, 1'b1);
            read_compare(MP_BASE | MP_STATUS, 32'(rx_pkts));
         end
         while (rx_q.size() != 0) begin
            f = rx_q.pop_front();
            read_compare(MP_BASE | MP_RECV, f.data);
            if (f.ftype inside {TAIL, SINGLE}) rx_pkts--;
            check_equal("irq_o", irq, rx_pkts > 0);
         end
      end
      read_compare(MP_BASE | MP_RECV, 32'h0);
      // Full send queue stalls the bus
      set_ready_mode(1);
      for (int i = 0; i < FIFO_DEPTH; i++) mp_write(1'b0, next_rand());
      @(negedge clk);
      wbs_cyc = 1'b1;
      wbs_stb = 1'b1;
      wbs_we  = 1'b1;
      wbs_adr = MP_BASE | MP_SEND_END;
      wbs_dat = next_rand();
      repeat (4) begin
         @(posedge clk);
         check_equal("wbs_ack_o", wbs_ack, 1'b0);
      end
      ready_mode = 2;
      @(posedge clk);
      while (!wbs_ack) @(posedge clk);
      expect_send(1'b1, wbs_dat);
      @(negedge clk);
      wbs_cyc = 1'b0;
      wbs_stb = 1'b0;
      wbs_we  = 1'b0;
      while (exp_out.size() != 0) @(posedge clk);
      repeat (2) @(posedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) $display("Everything OK");
      else             $display("Something failed");
      $finish;
   end

endmodule

/* filelist.f */
hdl/na_pkg.sv
hdl/na_flit_fifo.sv
hdl/na_bus_slave.sv
hdl/na_mp_send.sv
hdl/na_mp_recv.sv
hdl/na_compute_tile.sv
tb/tb_na_compute_tile.sv

/* Bender.yml */
package:
  name: na_compute_tile

sources:
  - hdl/na_pkg.sv
  - hdl/na_flit_fifo.sv
  - hdl/na_bus_slave.sv
  - hdl/na_mp_send.sv
  - hdl/na_mp_recv.sv
  - hdl/na_compute_tile.sv
  - target: simulation
    files:
      - tb/tb_na_compute_tile.sv
